//--- lane_delay.sv
module lane_delay #(
	parameter int AMOUNT = 0 // delay in bit clocks, 0 to 7
) (
	input logic bit_clock,
	input logic rst_n,
	input logic bit_in,
	output logic bit_out
);

	if (AMOUNT == 0) begin : g_bypass
		assign bit_out = bit_in; // no delay, straight through
	end else begin : g_line
		logic [AMOUNT-1:0] stages; // stage 0 takes the input

		always_ff @(posedge bit_clock) begin
			if (!rst_n)
				stages <= '0;
			else
				stages <= AMOUNT'({stages, bit_in}); // upper bits fall off the end
		end

		assign bit_out = stages[AMOUNT-1]; // oldest stage
	end

endmodule

//--- lane_serializer.sv
module lane_serializer #(
	parameter int NUM_LANES = ocyrus_pkg::NUM_LANES,
	parameter int BIT_DEPTH = ocyrus_pkg::BIT_DEPTH
) (
	input logic bit_clock,
	input logic rst_n,
	input logic strobe, // load edge, last bit of the current word is on the wire
	input ocyrus_pkg::frame_t head,
	input logic nonempty,
	output logic pop, // take the head frame at this strobe
	output ocyrus_pkg::lane_bits_t serial_bits // msb of each shift register
);

	logic [NUM_LANES*BIT_DEPTH-1:0] head_bits; // frame flattened, lane 0 lowest
	logic [NUM_LANES-1:0][BIT_DEPTH-1:0] shreg; // one shift register per lane
	logic [NUM_LANES-1:0][BIT_DEPTH-1:0] load_word; // what goes in at the strobe

	assign head_bits = head;

	// only pop when there is something to pop
	assign pop = strobe & nonempty;

	// pick frame data or idle filler, all lanes together
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (nonempty)
				load_word[i] = head_bits[i*BIT_DEPTH +: BIT_DEPTH];
			else
				load_word[i] = ocyrus_pkg::IDLE_WORD; // underflow, send the filler
		end
	end

	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			shreg <= '0; // first word period after reset is all zeros
		end else if (strobe) begin
			shreg <= load_word;
		end else begin
			for (int i = 0; i < NUM_LANES; i++)
				shreg[i] <= {shreg[i][BIT_DEPTH-2:0], 1'b0}; // shift left, msb first
		end
	end

	// wire each lane's msb out
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++)
			serial_bits[i] = shreg[i][BIT_DEPTH-1];
	end

endmodule

//--- list.f
ocyrus_pkg.sv
strobe_generator.sv
word_fifo.sv
lane_serializer.sv
lane_delay.sv
ocyrus_top.sv
ocyrus_assertions.sv
tb_ocyrus.sv

//--- ocyrus_assertions.sv
module ocyrus_assertions #(
	parameter int FIFO_DEPTH = ocyrus_pkg::FIFO_DEPTH
) (
	input logic bit_clock,
	input logic rst_n,
	input logic word_valid,
	input logic pop,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] count, // fifo occupancy
	input logic credit_return
);

	// sender may only push with a credit, so never into a full fifo
	assert property (@(posedge bit_clock) disable iff (!rst_n)
		word_valid |-> (count != FIFO_DEPTH))
		else $error("push while fifo full");

	// serializer pops only with data waiting
	assert property (@(posedge bit_clock) disable iff (!rst_n)
		pop |-> (count != '0))
		else $error("pop while fifo empty");

	// a credit pulse exactly when one word left the fifo on the edge before
	assert property (@(posedge bit_clock) disable iff (!rst_n)
		credit_return == (count + 1'b1 == $past(count) + $past(word_valid)))
		else $error("credit_return does not match a word taken out one clock earlier");

endmodule

bind word_fifo ocyrus_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) u_checks (
	.bit_clock(bit_clock),
	.rst_n(rst_n),
	.word_valid(word_valid),
	.pop(pop),
	.count(count),
	.credit_return(credit_return)
);

//--- ocyrus_pkg.sv
package ocyrus_pkg;

	parameter int NUM_LANES = 4; // serial outputs
	parameter int BIT_DEPTH = 8; // bits per word, also bit clocks per word period
	parameter int FIFO_DEPTH = 4; // fifo entries, sender starts with this many credits

	// one lane's word, msb is sent first
	typedef logic [BIT_DEPTH-1:0] lane_word_t;

	// one word per lane, lane 0 in the low bits
	typedef struct packed {
		lane_word_t lane3;
		lane_word_t lane2;
		lane_word_t lane1;
		lane_word_t lane0;
	} frame_t;

	// one bit per lane, bit i belongs to lane i
	typedef logic [NUM_LANES-1:0] lane_bits_t;

	// filler pattern when the fifo runs dry at a strobe
	parameter lane_word_t IDLE_WORD = 8'hf0; // high nibble ones, low nibble zeros

	// per-lane output delay in bit clocks, nibble i for lane i, max 7 each
	parameter logic [NUM_LANES-1:0][3:0] DEFAULT_LANE_DELAYS = {
		4'd6, // lane 3
		4'd3, // lane 2
		4'd1, // lane 1
		4'd0 // lane 0
	};

endpackage

//--- ocyrus_top.sv
module ocyrus_top #(
	parameter int NUM_LANES = ocyrus_pkg::NUM_LANES,
	parameter int BIT_DEPTH = ocyrus_pkg::BIT_DEPTH,
	parameter int FIFO_DEPTH = ocyrus_pkg::FIFO_DEPTH,
	parameter logic [NUM_LANES-1:0][3:0] LANE_DELAYS = ocyrus_pkg::DEFAULT_LANE_DELAYS
) (
	input logic bit_clock,
	input logic rst_n,
	input logic word_valid, // sender push, spends one credit
	input ocyrus_pkg::frame_t word_in,
	output logic credit_return, // one pulse per word taken out of the fifo
	output logic word_clock, // frame marker, aligned to undelayed lane data
	output ocyrus_pkg::lane_bits_t d_out // delayed serial outputs
);

	logic strobe;
	logic pop;
	logic nonempty;
	ocyrus_pkg::frame_t head;
	ocyrus_pkg::lane_bits_t serial_bits; // serializer output before the delay lines

	strobe_generator #(.BIT_DEPTH(BIT_DEPTH)) u_strobe (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.strobe(strobe),
		.word_clock(word_clock)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.word_valid(word_valid),
		.word_in(word_in),
		.pop(pop),
		.head(head),
		.nonempty(nonempty),
		.credit_return(credit_return)
	);

	lane_serializer #(.NUM_LANES(NUM_LANES), .BIT_DEPTH(BIT_DEPTH)) u_ser (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.strobe(strobe),
		.head(head),
		.nonempty(nonempty),
		.pop(pop),
		.serial_bits(serial_bits)
	);

	// one fixed delay line per lane
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_delay #(.AMOUNT(int'(LANE_DELAYS[i]))) u_delay (
			.bit_clock(bit_clock),
			.rst_n(rst_n),
			.bit_in(serial_bits[i]),
			.bit_out(d_out[i])
		);
	end

endmodule

//--- run.sh
#!/bin/sh
# compile with verilator, run, and decide pass or fail from the simulation output
verilator --binary --timing --assert -Wno-fatal --top-module tb_ocyrus -f list.f \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_ocyrus)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- strobe_generator.sv
module strobe_generator #(
	parameter int BIT_DEPTH = ocyrus_pkg::BIT_DEPTH // bit clocks per word period
) (
	input logic bit_clock,
	input logic rst_n,
	output logic strobe, // one bit clock per word period, marks the load edge
	output logic word_clock // registered, high for first half of each word on the wire
);

	localparam int CW = (BIT_DEPTH > 1) ? $clog2(BIT_DEPTH) : 1;
	localparam int HALF = BIT_DEPTH / 2;

	logic [CW-1:0] cnt; // position inside the word period
	logic [CW-1:0] cnt_next;

	// strobe sits on the last bit of the period
	assign strobe = (cnt == CW'(BIT_DEPTH - 1));

	// wrap back to 0 right after the strobe edge
	assign cnt_next = strobe ? '0 : cnt + 1'b1;

	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			cnt <= '0;
			word_clock <= 1'b0; // stays low through reset
		end else begin
			cnt <= cnt_next;
			// look ahead one cycle so the register lines up with serial_bits
			word_clock <= (cnt_next < CW'(HALF));
		end
	end

endmodule

//--- tb_ocyrus.sv
module tb_ocyrus;

	localparam int NL = ocyrus_pkg::NUM_LANES;
	localparam int BD = ocyrus_pkg::BIT_DEPTH;
	localparam int FD = ocyrus_pkg::FIFO_DEPTH;
	localparam logic [NL-1:0][3:0] DELAYS = {4'd6, 4'd3, 4'd1, 4'd0}; // lane 3 down to lane 0
	localparam ocyrus_pkg::lane_word_t IDLE_EXP = 8'hf0; // high nibble ones, low nibble zeros
	localparam int TIMEOUT = 300 * BD + 100; // longest run is about 190 word periods

	logic bit_clock;
	logic rst_n;
	logic word_valid;
	ocyrus_pkg::frame_t word_in;
	logic credit_return;
	logic word_clock;
	ocyrus_pkg::lane_bits_t d_out;

	ocyrus_pkg::frame_t fifo_q[$]; // frames the fifo holds, oldest first
	ocyrus_pkg::frame_t cur_frame; // frame on the serial lanes in this period
	ocyrus_pkg::lane_bits_t hist[8]; // undelayed lane bits, hist[k] is k cycles old
	int m_cnt; // position inside the word period
	int credits; // sender side credit count
	int sent;
	int returned;
	int idle_periods;
	int cycles = 0;
	bit stall_seen;

	ocyrus_top #(
		.NUM_LANES(NL),
		.BIT_DEPTH(BD),
		.FIFO_DEPTH(FD),
		.LANE_DELAYS(DELAYS)
	) dut (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.word_valid(word_valid),
		.word_in(word_in),
		.credit_return(credit_return),
		.word_clock(word_clock),
		.d_out(d_out)
	);

	initial begin
		bit_clock = 1'b0;
		forever #20 bit_clock = ~bit_clock;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_bit(input string name, input ocyrus_pkg::lane_bits_t exp,
			input ocyrus_pkg::lane_bits_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
				$time, name, exp, act));
	endtask

	// one bit clock: model the edge, check outputs, then drive the next inputs
	// mode 0 sends nothing, 1 sends with random gaps, 2 sends whenever a credit is held
	task automatic run_cycle(input int mode);
		logic strobe_m;
		logic exp_credit;
		logic do_send;
		logic [NL*BD-1:0] flat;
		ocyrus_pkg::lane_bits_t ser;
		ocyrus_pkg::lane_bits_t exp_d;
		ocyrus_pkg::frame_t f;
		@(posedge bit_clock);
		strobe_m = (m_cnt == BD - 1); // last bit of the period was on the wire
		exp_credit = 1'b0;
		if (strobe_m) begin
			if (fifo_q.size() > 0) begin
				cur_frame = fifo_q.pop_front(); // emptiness seen before this edge's push
				exp_credit = 1'b1;
			end else begin
				cur_frame = ocyrus_pkg::frame_t'({NL{IDLE_EXP}});
				idle_periods++;
			end
		end
		if (word_valid)
			fifo_q.push_back(word_in); // accepted on this edge
		m_cnt = strobe_m ? 0 : m_cnt + 1;
		flat = cur_frame;
		for (int i = 0; i < NL; i++)
			ser[i] = flat[i*BD + BD - 1 - m_cnt]; // msb first
		for (int k = 7; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = ser;
		for (int i = 0; i < NL; i++)
			exp_d[i] = hist[DELAYS[i]][i];
		#5;
		check_bit("d_out", exp_d, d_out);
		check_flag("word_clock", m_cnt < BD / 2, word_clock);
		check_flag("credit_return", exp_credit, credit_return);
		if (credit_return) begin
			credits++; // usable right away for the next edge
			returned++;
		end
		if (mode == 2 && credits == 0)
			stall_seen = 1'b1;
		case (mode)
			1: do_send = ($urandom_range(0, 1) == 1) && (credits > 0);
			2: do_send = (credits > 0);
			default: do_send = 1'b0;
		endcase
		f = ocyrus_pkg::frame_t'($urandom()); // payload is random even when not valid
		if (do_send) begin
			credits--;
			sent++;
		end
		word_valid = do_send;
		word_in = f;
	endtask

	// cycle budget against a stuck drain loop
	always @(posedge bit_clock) begin
		cycles++;
		if (cycles > TIMEOUT)
			fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT));
	end

	initial begin
		void'($urandom(32'hd335));
		rst_n = 1'b0;
		word_valid = 1'b0;
		word_in = '0;
		m_cnt = 0;
		cur_frame = '0; // first period after reset carries zeros
		credits = FD;
		sent = 0;
		returned = 0;
		idle_periods = 0;
		stall_seen = 1'b0;
		for (int k = 0; k < 8; k++)
			hist[k] = '0;
		repeat (3) @(posedge bit_clock);
		#5;
		check_bit("d_out", '0, d_out); // state held in reset
		check_flag("word_clock", 1'b0, word_clock);
		check_flag("credit_return", 1'b0, credit_return);
		rst_n = 1'b1;
		repeat (80 * BD) run_cycle(1); // random traffic with gaps
		repeat (40 * BD) run_cycle(2); // burst, stalls on zero credit
		repeat (10 * BD) run_cycle(0); // quiet, lanes fall back to idle words
		repeat (60 * BD) run_cycle(1);
		while (fifo_q.size() > 0)
			run_cycle(0);
		repeat (2 * BD) run_cycle(0); // last word through the longest delay line
		check_count("sender credits after drain", FD, credits);
		check_count("credit pulses", sent, returned);
		if (idle_periods == 0) begin
			fail_run("no word period carried the idle word");
		end else if (!stall_seen) begin
			fail_run("the burst never used up all sender credits");
		end else begin
			$display("sent %0d frames, %0d idle periods", sent, idle_periods);
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

//--- word_fifo.sv
module word_fifo #(
	parameter int FIFO_DEPTH = ocyrus_pkg::FIFO_DEPTH // entries, equal to sender credits
) (
	input logic bit_clock,
	input logic rst_n,
	input logic word_valid, // sender push, only ever with a credit in hand
	input ocyrus_pkg::frame_t word_in,
	input logic pop, // from the serializer on a strobe with data waiting
	output ocyrus_pkg::frame_t head, // oldest frame, valid while nonempty
	output logic nonempty,
	output logic credit_return // pop delayed one clock, hands a credit back
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	ocyrus_pkg::frame_t mem [FIFO_DEPTH]; // storage, no reset needed

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count; // occupancy

	// circular increment, works for depths that are not a power of two
	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		logic [PW-1:0] r;
		if (p == PW'(FIFO_DEPTH - 1))
			r = '0;
		else
			r = p + 1'b1;
		return r;
	endfunction

	assign head = mem[rd_ptr]; // show-ahead read
	assign nonempty = (count != '0);

	// write side, room is guaranteed by the credit scheme
	always_ff @(posedge bit_clock) begin
		if (word_valid)
			mem[wr_ptr] <= word_in;
	end

	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (word_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			// push and pop together leave the count alone
			case ({word_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_return <= pop; // one clock after the pop, one pulse per word
		end
	end

endmodule
